// File: core_config.svh
/*
  Sizing for the lockstep core. CORE_IDLE_CYCLES and CORE_LOCKSTEP_DELAY
  must be at least 1. CORE_REG_AW has to cover CORE_NUM_REGS.
*/
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Datapath
`define CORE_XLEN 32
`define CORE_NUM_REGS 16
`define CORE_REG_AW 4
`define CORE_IMM_W 16

// Shadow core trails the main core by this many cycles
`define CORE_LOCKSTEP_DELAY 2

// Idle run cycles before the core drops into sleep
`define CORE_IDLE_CYCLES 4

`endif

// File: core_pkg.sv
/*
  Types shared by the main and shadow datapaths.
  Opcodes 6 and 7 are not defined and produce a zero result.
*/
`include "core_config.svh"

package core_pkg;

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_LI  = 3'd5
  } opcode_e;

  typedef enum logic [1:0] {
    ST_RESET = 2'd0,
    ST_RUN   = 2'd1,
    ST_SLEEP = 2'd2
  } ctrl_state_e;

  // Immediate is only used by OP_LI
  typedef struct packed {
    opcode_e                 op;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_REG_AW-1:0] rs1;
    logic [`CORE_REG_AW-1:0] rs2;
    logic [`CORE_IMM_W-1:0]  imm;
  } instr_t;

  typedef struct packed {
    logic                    we;
    logic [`CORE_REG_AW-1:0] waddr;
    logic [`CORE_XLEN-1:0]   wdata;
  } wb_t;

endpackage

// File: core_regfile.sv
/*
  Flop register file, two combinational reads and one write.
  Register 0 reads zero and ignores writes.
*/
`timescale 1ns/1ps
`include "core_config.svh"

module core_regfile (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [`CORE_REG_AW-1:0] raddr_a_i,
  input  logic [`CORE_REG_AW-1:0] raddr_b_i,
  output logic [`CORE_XLEN-1:0]   rdata_a_o,
  output logic [`CORE_XLEN-1:0]   rdata_b_o,
  input  core_pkg::wb_t           wr_i
);

  logic [`CORE_XLEN-1:0] regs_q [`CORE_NUM_REGS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.we && (wr_i.waddr != '0)) begin
      regs_q[wr_i.waddr] <= wr_i.wdata;
    end
  end

  // Hardwired zero for register 0
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// File: core_exec.sv
/*
  Single-cycle execute. The result writes the register file in the issue
  cycle and shows on wb_o one cycle later. No forwarding is needed.
*/
`timescale 1ns/1ps
`include "core_config.svh"

module core_exec (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    issue_i,
  input  core_pkg::instr_t        instr_i,
  input  logic [`CORE_XLEN-1:0]   rdata_a_i,
  input  logic [`CORE_XLEN-1:0]   rdata_b_i,
  output logic [`CORE_REG_AW-1:0] raddr_a_o,
  output logic [`CORE_REG_AW-1:0] raddr_b_o,
  output core_pkg::wb_t           rf_wr_o,
  output core_pkg::wb_t           wb_o
);

  logic [`CORE_XLEN-1:0]   result;
  logic                    wb_we_q;
  logic [`CORE_REG_AW-1:0] wb_waddr_q;
  logic [`CORE_XLEN-1:0]   wb_wdata_q;

  assign raddr_a_o = instr_i.rs1;
  assign raddr_b_o = instr_i.rs2;

  //////////////////////////////
  // Decode and ALU
  //////////////////////////////

  always_comb begin
    case (instr_i.op)
      core_pkg::OP_ADD: result = rdata_a_i + rdata_b_i;
      core_pkg::OP_SUB: result = rdata_a_i - rdata_b_i;
      core_pkg::OP_AND: result = rdata_a_i & rdata_b_i;
      core_pkg::OP_OR:  result = rdata_a_i | rdata_b_i;
      core_pkg::OP_XOR: result = rdata_a_i ^ rdata_b_i;
      core_pkg::OP_LI:  result = {{(`CORE_XLEN - `CORE_IMM_W){1'b0}}, instr_i.imm};
      default:          result = '0;
    endcase
  end

  assign rf_wr_o = '{we: issue_i, waddr: instr_i.rd, wdata: result};

  //////////////////////////////
  // Writeback register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_we_q <= 1'b0;
    end else begin
      wb_we_q <= issue_i;
    end
  end

  // Payload only moves on issue
  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      wb_waddr_q <= instr_i.rd;
      wb_wdata_q <= result;
    end
  end

  assign wb_o = '{we: wb_we_q, waddr: wb_waddr_q, wdata: wb_wdata_q};

  wb_we_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(wb_o.we));

endmodule

// File: core_idle_timer.sv
/*
  Counts back-to-back run cycles with no issue. expire_o is a single
  combinational pulse on the CORE_IDLE_CYCLES-th such cycle.
*/
`timescale 1ns/1ps
`include "core_config.svh"

module core_idle_timer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic run_i,
  input  logic issue_i,
  output logic expire_o
);

  localparam int unsigned IdleCycles = `CORE_IDLE_CYCLES;
  localparam int unsigned CntW       = $clog2(IdleCycles + 1);

  logic [CntW-1:0] idle_cnt_q;

  // Saturates at the threshold so the pulse fires once
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idle_cnt_q <= '0;
    end else if (!run_i || issue_i) begin
      idle_cnt_q <= '0;
    end else if (idle_cnt_q != CntW'(IdleCycles)) begin
      idle_cnt_q <= idle_cnt_q + 1'b1;
    end
  end

  assign expire_o = run_i & ~issue_i & (idle_cnt_q == CntW'(IdleCycles - 1));

endmodule

// File: core_ctrl_fsm.sv
/*
  Reset, run and sleep control. Issue is only possible in run.
  Run is left only through the idle timer, and sleep only through wake_i.
*/
`timescale 1ns/1ps

module core_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic fetch_enable_i,
  input  logic wake_i,
  input  logic instr_valid_i,
  input  logic expire_i,
  output logic issue_o,
  output logic run_o,
  output logic core_sleep_o
);

  core_pkg::ctrl_state_e state_q, state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      core_pkg::ST_RESET: begin
        if (fetch_enable_i) begin
          state_d = core_pkg::ST_RUN;
        end
      end
      core_pkg::ST_RUN: begin
        if (expire_i) begin
          state_d = core_pkg::ST_SLEEP;
        end
      end
      core_pkg::ST_SLEEP: begin
        if (wake_i) begin
          state_d = core_pkg::ST_RUN;
        end
      end
      default: state_d = core_pkg::ST_RESET;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= core_pkg::ST_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  // Instructions outside run are dropped here
  assign run_o        = (state_q == core_pkg::ST_RUN);
  assign issue_o      = instr_valid_i & run_o;
  assign core_sleep_o = ~run_o;

  // Without a wake or enable the core stays quiet for the next cycle too
  sleep_holds_issue_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o && !wake_i && !fetch_enable_i |=> !issue_o);

endmodule

// File: core_lockstep.sv
/*
  Shadow copy of the datapath fed CORE_LOCKSTEP_DELAY cycles late.
  Any writeback difference sets alert_major_o until reset.
*/
`timescale 1ns/1ps
`include "core_config.svh"

module core_lockstep (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             issue_i,
  input  core_pkg::instr_t instr_i,
  input  core_pkg::wb_t    main_wb_i,
  output logic             alert_major_o
);

  localparam int unsigned Delay = `CORE_LOCKSTEP_DELAY;

  logic [Delay-1:0]        issue_q;
  core_pkg::instr_t        instr_q [Delay];
  logic [Delay-1:0]        main_we_q;
  logic [`CORE_REG_AW-1:0] main_waddr_q [Delay];
  logic [`CORE_XLEN-1:0]   main_wdata_q [Delay];
  core_pkg::wb_t           main_wb_dly;
  core_pkg::wb_t           shadow_wb;
  core_pkg::wb_t           shadow_rf_wr;
  logic [`CORE_REG_AW-1:0] shadow_raddr_a;
  logic [`CORE_REG_AW-1:0] shadow_raddr_b;
  logic [`CORE_XLEN-1:0]   shadow_rdata_a;
  logic [`CORE_XLEN-1:0]   shadow_rdata_b;
  logic                    mismatch;
  logic                    alert_q;

  //////////////////////////////
  // Delay lines
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_q   <= '0;
      main_we_q <= '0;
    end else begin
      issue_q[0]   <= issue_i;
      main_we_q[0] <= main_wb_i.we;
      for (int i = 1; i < Delay; i++) begin
        issue_q[i]   <= issue_q[i-1];
        main_we_q[i] <= main_we_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    instr_q[0]      <= instr_i;
    main_waddr_q[0] <= main_wb_i.waddr;
    main_wdata_q[0] <= main_wb_i.wdata;
    for (int i = 1; i < Delay; i++) begin
      instr_q[i]      <= instr_q[i-1];
      main_waddr_q[i] <= main_waddr_q[i-1];
      main_wdata_q[i] <= main_wdata_q[i-1];
    end
  end

  assign main_wb_dly = '{we:    main_we_q[Delay-1],
                         waddr: main_waddr_q[Delay-1],
                         wdata: main_wdata_q[Delay-1]};

  //////////////////////////////
  // Shadow datapath
  //////////////////////////////

  core_exec u_shadow_exec (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .issue_i   (issue_q[Delay-1]),
    .instr_i   (instr_q[Delay-1]),
    .rdata_a_i (shadow_rdata_a),
    .rdata_b_i (shadow_rdata_b),
    .raddr_a_o (shadow_raddr_a),
    .raddr_b_o (shadow_raddr_b),
    .rf_wr_o   (shadow_rf_wr),
    .wb_o      (shadow_wb)
  );

  core_regfile u_shadow_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (shadow_raddr_a),
    .raddr_b_i (shadow_raddr_b),
    .rdata_a_o (shadow_rdata_a),
    .rdata_b_o (shadow_rdata_b),
    .wr_i      (shadow_rf_wr)
  );

  // Payload only counts when a write is flagged
  assign mismatch = (main_wb_dly.we != shadow_wb.we) ||
                    (main_wb_dly.we && ((main_wb_dly.waddr != shadow_wb.waddr) ||
                                        (main_wb_dly.wdata != shadow_wb.wdata)));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= alert_q | mismatch;
    end
  end

  assign alert_major_o = alert_q;

  alert_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(alert_major_o));

endmodule

// File: core_top.sv
/*
  Lockstep-protected core. Instructions seen while core_sleep_o is high
  are dropped without a trace. There is no back-pressure.
*/
`timescale 1ns/1ps
`include "core_config.svh"

module core_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             fetch_enable_i,
  input  logic             wake_i,
  input  logic             instr_valid_i,
  input  core_pkg::instr_t instr_i,
  output core_pkg::wb_t    wb_o,
  output logic             core_sleep_o,
  output logic             alert_major_o
);

  logic                    issue;
  logic                    run;
  logic                    expire;
  logic [`CORE_REG_AW-1:0] rf_raddr_a;
  logic [`CORE_REG_AW-1:0] rf_raddr_b;
  logic [`CORE_XLEN-1:0]   rf_rdata_a;
  logic [`CORE_XLEN-1:0]   rf_rdata_b;
  core_pkg::wb_t           rf_wr;

  //////////////////////////////
  // Control
  //////////////////////////////

  core_ctrl_fsm u_ctrl_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .wake_i         (wake_i),
    .instr_valid_i  (instr_valid_i),
    .expire_i       (expire),
    .issue_o        (issue),
    .run_o          (run),
    .core_sleep_o   (core_sleep_o)
  );

  core_idle_timer u_idle_timer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .run_i    (run),
    .issue_i  (issue),
    .expire_o (expire)
  );

  //////////////////////////////
  // Main datapath
  //////////////////////////////

  core_exec u_exec (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .issue_i   (issue),
    .instr_i   (instr_i),
    .rdata_a_i (rf_rdata_a),
    .rdata_b_i (rf_rdata_b),
    .raddr_a_o (rf_raddr_a),
    .raddr_b_o (rf_raddr_b),
    .rf_wr_o   (rf_wr),
    .wb_o      (wb_o)
  );

  core_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .wr_i      (rf_wr)
  );

  core_lockstep u_lockstep (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_i       (issue),
    .instr_i       (instr_i),
    .main_wb_i     (wb_o),
    .alert_major_o (alert_major_o)
  );

endmodule

// File: tb_core_checker.sv
/*
  Watches the core ports and predicts every writeback from a register
  model. Run and sleep are modelled from fetch enable, wake and the idle
  rule. Fixed one-cycle writeback latency is assumed.
*/
`timescale 1ns/1ps
`include "core_config.svh"

module tb_core_checker (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             fetch_enable_i,
  input  logic             wake_i,
  input  logic             instr_valid_i,
  input  core_pkg::instr_t instr_i,
  input  core_pkg::wb_t    wb_i,
  input  logic             core_sleep_i,
  input  logic             alert_major_i,
  input  int               test_id_i,
  input  int               done_id_i,
  input  int               tb_errors_i,
  input  logic             report_i,
  output int               errors_o
);

  logic [`CORE_XLEN-1:0] model_q [`CORE_NUM_REGS];
  core_pkg::wb_t         exp_wb;
  core_pkg::wb_t         next_wb;
  int                    checks = 0;
  int                    errors = 0;
  int                    err_mark = 0;
  int                    test_err;
  int                    tests_run = 0;
  int                    tests_failed = 0;
  int                    last_done = 0;
  int                    label_id;
  logic                  alert_seen;
  logic                  awake_m;
  logic                  started_m;
  int                    idle_m;

  function automatic string test_label(int id);
    case (id)
      1:       return "reset_exit";
      2:       return "directed_ops";
      3:       return "random_stream";
      4:       return "sleep_entry";
      5:       return "wake_restore";
      6:       return "alert_quiet";
      default: return "unknown";
    endcase
  endfunction

  function automatic logic [`CORE_XLEN-1:0] reg_value(logic [`CORE_REG_AW-1:0] addr);
    if (addr == '0) begin
      return '0;
    end
    return model_q[addr];
  endfunction

  // Expected result from the opcode definitions
  function automatic logic [`CORE_XLEN-1:0] ref_result(core_pkg::instr_t ins,
                                                       logic [`CORE_XLEN-1:0] a,
                                                       logic [`CORE_XLEN-1:0] b);
    logic [`CORE_XLEN-1:0] imm_ext;
    imm_ext = '0;
    imm_ext[`CORE_IMM_W-1:0] = ins.imm;
    case (ins.op)
      core_pkg::OP_ADD: return a + b;
      core_pkg::OP_SUB: return a - b;
      core_pkg::OP_AND: return a & b;
      core_pkg::OP_OR:  return a | b;
      core_pkg::OP_XOR: return a ^ b;
      core_pkg::OP_LI:  return imm_ext;
      default:          return '0;
    endcase
  endfunction

  //////////////////////////////
  // Compare and predict
  //////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        model_q[i] = '0;
      end
      exp_wb     = '0;
      alert_seen = 1'b0;
      awake_m    = 1'b0;
      started_m  = 1'b0;
      idle_m     = 0;
    end else begin
      // Last edge of a test is still labelled with that test
      label_id = (done_id_i != last_done) ? done_id_i : test_id_i;
      checks++;
      if ((wb_i.we !== exp_wb.we) ||
          (exp_wb.we && ((wb_i.waddr !== exp_wb.waddr) || (wb_i.wdata !== exp_wb.wdata)))) begin
        errors++;
        $display("FAILED %0s: expected we=%0b rd=%0d data=%08h, actual we=%0b rd=%0d data=%08h",
                 test_label(label_id), exp_wb.we, exp_wb.waddr, exp_wb.wdata,
                 wb_i.we, wb_i.waddr, wb_i.wdata);
      end
      if (core_sleep_i !== !awake_m) begin
        errors++;
        $display("FAILED %0s: expected core_sleep_o=%0b, actual core_sleep_o=%0b",
                 test_label(label_id), !awake_m, core_sleep_i);
      end
      next_wb = '0;
      if (instr_valid_i && awake_m) begin
        next_wb.we    = 1'b1;
        next_wb.waddr = instr_i.rd;
        next_wb.wdata = ref_result(instr_i, reg_value(instr_i.rs1), reg_value(instr_i.rs2));
        if (instr_i.rd != '0) begin
          model_q[instr_i.rd] = next_wb.wdata;
        end
      end
      exp_wb = next_wb;
      // Run and sleep model, fetch enable once out of reset, wake after that
      if (!awake_m) begin
        if (started_m ? wake_i : fetch_enable_i) begin
          awake_m   = 1'b1;
          started_m = 1'b1;
        end
        idle_m = 0;
      end else if (instr_valid_i) begin
        idle_m = 0;
      end else if (idle_m == `CORE_IDLE_CYCLES - 1) begin
        awake_m = 1'b0;
        idle_m  = 0;
      end else begin
        idle_m++;
      end
      if (alert_major_i && !alert_seen) begin
        alert_seen = 1'b1;
        errors++;
        $display("alert_major_o went high during %0s although both datapaths should agree",
                 test_label(label_id));
      end
      if (done_id_i != last_done) begin
        last_done = done_id_i;
        test_err  = errors + tb_errors_i - err_mark;
        err_mark  = errors + tb_errors_i;
        tests_run++;
        if (test_err != 0) begin
          tests_failed++;
        end
        $display("Test %0d %0s: %0s, %0d error(s)", done_id_i, test_label(done_id_i),
                 (test_err == 0) ? "pass" : "FAIL", test_err);
      end
      if (report_i) begin
        $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors + tb_errors_i);
      end
    end
  end

  assign errors_o = errors + tb_errors_i;

endmodule

// File: tb_core_top.sv
/*
  Testbench for core_top. Inputs change on the rising edge, levels are
  sampled on the falling edge. Random stimulus uses a fixed seed.
*/
`timescale 1ns/1ps
`include "core_config.svh"

module tb_core_top;

  localparam int NumRandom = 200;
  localparam int SleepWait = `CORE_IDLE_CYCLES + 3;
  localparam int WakeWait  = 4;

  logic             clk;
  logic             rst_n;
  logic             fetch_enable;
  logic             wake;
  logic             instr_valid;
  core_pkg::instr_t instr;
  core_pkg::wb_t    wb;
  logic             core_sleep;
  logic             alert_major;
  int               test_id;
  int               done_id;
  int               tb_errors;
  logic             report;
  int               total_errors;
  logic [31:0]      rng;
  logic             seen;
  core_pkg::instr_t ins;
  core_pkg::instr_t prev;

  core_top UUT (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .fetch_enable_i (fetch_enable),
    .wake_i         (wake),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .wb_o           (wb),
    .core_sleep_o   (core_sleep),
    .alert_major_o  (alert_major)
  );

  tb_core_checker u_checker (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .fetch_enable_i (fetch_enable),
    .wake_i         (wake),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .wb_i           (wb),
    .core_sleep_i   (core_sleep),
    .alert_major_i  (alert_major),
    .test_id_i      (test_id),
    .done_id_i      (done_id),
    .tb_errors_i    (tb_errors),
    .report_i       (report),
    .errors_o       (total_errors)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic core_pkg::instr_t make_instr(core_pkg::opcode_e op,
                                                  logic [`CORE_REG_AW-1:0] rd,
                                                  logic [`CORE_REG_AW-1:0] rs1,
                                                  logic [`CORE_REG_AW-1:0] rs2,
                                                  logic [`CORE_IMM_W-1:0] imm);
    core_pkg::instr_t i;
    i.op  = op;
    i.rd  = rd;
    i.rs1 = rs1;
    i.rs2 = rs2;
    i.imm = imm;
    return i;
  endfunction

  //////////////////////////////
  // Drive helpers
  //////////////////////////////

  task automatic send(core_pkg::instr_t i);
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= i;
  endtask

  task automatic idle(int cycles);
    repeat (cycles) begin
      @(posedge clk);
      instr_valid <= 1'b0;
    end
  endtask

  task automatic check_level(string name, string what, logic expected, logic actual);
    if (actual !== expected) begin
      tb_errors++;
      $display("FAILED %0s: %0s expected %0b, actual %0b", name, what, expected, actual);
    end
  endtask

  // Polls core_sleep_o on falling edges until it reaches the level
  task automatic wait_sleep_level(logic level, int limit, output logic found);
    found = 1'b0;
    for (int n = 0; n < limit && !found; n++) begin
      @(negedge clk);
      if (core_sleep == level) begin
        found = 1'b1;
      end
    end
  endtask

  task automatic end_test();
    @(negedge clk);
    if (alert_major !== 1'b0) begin
      tb_errors++;
      $display("alert_major_o is not low at the end of test %0d", test_id);
    end
    @(posedge clk);
    instr_valid <= 1'b0;
    done_id     <= test_id;
    test_id     <= test_id + 1;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    wake         = 1'b0;
    instr_valid  = 1'b0;
    instr        = '0;
    test_id      = 1;
    done_id      = 0;
    tb_errors    = 0;
    report       = 1'b0;
    rng          = 32'h5957_ecac;
    prev         = '0;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Reset state, then leave reset with fetch enable
    @(negedge clk);
    check_level("reset_exit", "core_sleep_o", 1'b1, core_sleep);
    check_level("reset_exit", "wb_o.we", 1'b0, wb.we);
    check_level("reset_exit", "alert_major_o", 1'b0, alert_major);
    @(posedge clk);
    fetch_enable <= 1'b1;
    @(negedge clk);
    check_level("reset_exit", "core_sleep_o before sample", 1'b1, core_sleep);
    @(negedge clk);
    check_level("reset_exit", "core_sleep_o after sample", 1'b0, core_sleep);
    end_test();

    // Every opcode with known operands
    send(make_instr(core_pkg::OP_LI,  4'd1, 4'd0, 4'd0, 16'h1234));
    send(make_instr(core_pkg::OP_LI,  4'd2, 4'd0, 4'd0, 16'hf0f0));
    send(make_instr(core_pkg::OP_ADD, 4'd3, 4'd1, 4'd2, 16'h0000));
    send(make_instr(core_pkg::OP_SUB, 4'd4, 4'd1, 4'd2, 16'h0000));
    send(make_instr(core_pkg::OP_AND, 4'd5, 4'd1, 4'd2, 16'h0000));
    send(make_instr(core_pkg::OP_OR,  4'd6, 4'd1, 4'd2, 16'h0000));
    send(make_instr(core_pkg::OP_XOR, 4'd7, 4'd1, 4'd2, 16'h0000));
    send(make_instr(core_pkg::OP_LI,  4'd0, 4'd0, 4'd0, 16'hbeef));
    send(make_instr(core_pkg::OP_ADD, 4'd8, 4'd0, 4'd0, 16'h0000));
    send(make_instr(core_pkg::OP_ADD, 4'd9, 4'd3, 4'd0, 16'h0000));
    end_test();

    // Back to back, every second one reads the previous destination
    for (int i = 0; i < NumRandom; i++) begin
      rng     = xorshift32(rng);
      ins.op  = core_pkg::opcode_e'(3'(rng % 32'd6));
      ins.rd  = rng[4 +: `CORE_REG_AW];
      ins.rs1 = rng[8 +: `CORE_REG_AW];
      ins.rs2 = rng[12 +: `CORE_REG_AW];
      ins.imm = rng[16 +: `CORE_IMM_W];
      if (i % 2 == 1) begin
        ins.rs1 = prev.rd;
      end
      send(ins);
      prev = ins;
    end
    end_test();

    // Idle until sleep, then present instructions that must be dropped
    wait_sleep_level(1'b1, SleepWait, seen);
    if (!seen) begin
      tb_errors++;
      $display("core_sleep_o did not rise within %0d cycles of the last issue", SleepWait);
    end
    for (int r = 1; r <= 5; r++) begin
      send(make_instr(core_pkg::OP_LI, 4'(r), 4'd0, 4'd0, 16'h5a00));
    end
    @(negedge clk);
    check_level("sleep_entry", "core_sleep_o while dropping", 1'b1, core_sleep);
    end_test();

    // Wake and read every register back through rs2 = 0
    @(posedge clk);
    wake <= 1'b1;
    wait_sleep_level(1'b0, WakeWait, seen);
    if (!seen) begin
      tb_errors++;
      $display("core_sleep_o did not fall within %0d cycles of wake_i", WakeWait);
    end
    for (int r = 1; r < `CORE_NUM_REGS; r++) begin
      send(make_instr(core_pkg::OP_ADD, 4'(r), 4'(r), 4'd0, 16'h0000));
    end
    wake <= 1'b0;
    end_test();

    // Lockstep needs a few cycles to compare the last writebacks
    idle(6);
    end_test();

    @(posedge clk);
    report <= 1'b1;
    @(posedge clk);
    report <= 1'b0;
    @(negedge clk);
    if (total_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
core_pkg.sv
core_regfile.sv
core_exec.sv
core_idle_timer.sv
core_ctrl_fsm.sv
core_lockstep.sv
core_top.sv
tb_core_checker.sv
tb_core_top.sv

// File: Makefile
# Verilator flow for the lockstep core

TOP := tb_core_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f vlog.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
